/* Makefile */
# Verilator build and run for the cpuCore testbench

VERILATOR ?= verilator
TOP       ?= cpuCoreTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@result="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* common/controlPkg.sv */
package controlPkg;

    // Timing steps with the fetch in T0 to T2
    typedef enum logic [3:0] {
        stepT0,
        stepT1,
        stepT2,
        stepT3,
        stepT4,
        stepT5,
        stepT6,
        stepHalted
    } step_t;

    // Which block drives the shared bus
    typedef enum logic [4:0] {
        srcNone,
        srcReg,
        srcHi,
        srcLo,
        srcPc,
        srcMdr,
        srcZlow,
        srcZhigh
    } busSrc_t;

endpackage

/* common/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and register width
`define WORD_WIDTH 32

// General registers R0 to R15
`define REG_COUNT 16

// Opcode field at the top of the instruction word
`define OPCODE_WIDTH 5

`endif

/* common/isaPkg.sv */
`include "core_settings.svh"

package isaPkg;

    // Instruction operations with the reference encodings for not and nop
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opLdw  = 5'b00000,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b01001,
        opShl  = 5'b01011,
        opNop  = 5'b01101,
        opMul  = 5'b01111,
        opDiv  = 5'b10000,
        opNeg  = 5'b10001,
        opNot  = 5'b10010,
        opOut  = 5'b10100,
        opMfhi = 5'b10110,
        opMflo = 5'b10111,
        opHalt = 5'b11011
    } opcode_t;

    // Register fields are wide enough to name every general register
    localparam int regFieldWidth = $clog2(`REG_COUNT);

    // Field positions with the opcode in 31..27 then ra, rb and rc
    localparam int opLsb = `WORD_WIDTH - `OPCODE_WIDTH;
    localparam int raLsb = opLsb - regFieldWidth;
    localparam int rbLsb = raLsb - regFieldWidth;
    localparam int rcLsb = rbLsb - regFieldWidth;

endpackage

/* datapath/alu.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module alu (
    input  logic [`WORD_WIDTH-1:0]   y,
    input  logic [`WORD_WIDTH-1:0]   busValue,
    input  isaPkg::opcode_t          aluOp,
    output logic [2*`WORD_WIDTH-1:0] result
);

    import isaPkg::*;

    localparam int wordWidth = `WORD_WIDTH;
    localparam int shiftBits = $clog2(`WORD_WIDTH);

    logic [shiftBits-1:0]   shiftAmount;
    logic [2*wordWidth-1:0] product;
    logic [wordWidth-1:0]   quotient;
    logic [wordWidth-1:0]   remainder;

    assign shiftAmount = busValue[shiftBits-1:0]; // Low five bits of rc only

    // Unsigned full-width product
    assign product = {{wordWidth{1'b0}}, y} * {{wordWidth{1'b0}}, busValue};

    always_comb begin
        if (busValue == '0) begin
            // Divide by zero gives an all ones quotient and leaves the dividend
            quotient  = '1;
            remainder = y;
        end else begin
            quotient  = y / busValue;
            remainder = y % busValue;
        end
    end

    always_comb begin
        result = '0; // High half stays zero except mul and div
        case (aluOp)
            opAdd: result[wordWidth-1:0] = y + busValue;
            opSub: result[wordWidth-1:0] = y - busValue;
            opAnd: result[wordWidth-1:0] = y & busValue;
            opOr:  result[wordWidth-1:0] = y | busValue;
            opShl: result[wordWidth-1:0] = y << shiftAmount;
            opShr: result[wordWidth-1:0] = y >> shiftAmount; // Logical shift
            opNot: result[wordWidth-1:0] = ~busValue;
            opNeg: result[wordWidth-1:0] = -busValue;
            opMul: result = product;
            opDiv: result = {remainder, quotient}; // HI gets remainder
            default: result = '0;
        endcase
    end

endmodule

/* datapath/busMux.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module busMux (
    input  logic                     clock,
    input  logic                     rst,
    input  logic [`REG_COUNT-1:0]    regOut,
    input  logic                     hiOut,
    input  logic                     loOut,
    input  logic                     pcOut,
    input  logic                     mdrOut,
    input  logic                     zLowOut,
    input  logic                     zHighOut,
    input  logic [`WORD_WIDTH-1:0]   regValue,
    input  logic [`WORD_WIDTH-1:0]   hiValue,
    input  logic [`WORD_WIDTH-1:0]   loValue,
    input  logic [`WORD_WIDTH-1:0]   pc,
    input  logic [`WORD_WIDTH-1:0]   mdr,
    input  logic [2*`WORD_WIDTH-1:0] zValue,
    output logic [`WORD_WIDTH-1:0]   busValue
);

    import controlPkg::*;

    busSrc_t source;

    // Strobe to source encoder
    always_comb begin
        if (|regOut)       source = srcReg;
        else if (hiOut)    source = srcHi;
        else if (loOut)    source = srcLo;
        else if (pcOut)    source = srcPc;
        else if (mdrOut)   source = srcMdr;
        else if (zLowOut)  source = srcZlow;
        else if (zHighOut) source = srcZhigh;
        else               source = srcNone;
    end

    always_comb begin
        case (source)
            srcReg:   busValue = regValue;
            srcHi:    busValue = hiValue;
            srcLo:    busValue = loValue;
            srcPc:    busValue = pc;
            srcMdr:   busValue = mdr;
            srcZlow:  busValue = zValue[`WORD_WIDTH-1:0];
            srcZhigh: busValue = zValue[2*`WORD_WIDTH-1:`WORD_WIDTH];
            default:  busValue = '0; // Idle bus reads as zero
        endcase
    end

    // Control unit drives at most one bus source per step
    singleSource: assert property (@(posedge clock) disable iff (rst)
        $onehot0({regOut, hiOut, loOut, pcOut, mdrOut, zLowOut, zHighOut}))
        else $error("busMux: bus driven by more than one source");

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module datapath (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   pcOut,
    input  logic                   pcIn,
    input  logic                   incPc,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   mdrOut,
    input  logic                   irIn,
    input  logic                   yIn,
    input  logic                   zIn,
    input  logic                   zLowOut,
    input  logic                   zHighOut,
    input  logic                   hiIn,
    input  logic                   hiOut,
    input  logic                   loIn,
    input  logic                   loOut,
    input  logic [`REG_COUNT-1:0]  regIn,
    input  logic [`REG_COUNT-1:0]  regOut,
    input  isaPkg::opcode_t        aluOp,
    input  logic [`WORD_WIDTH-1:0] memDataIn,
    input  logic                   memRead,
    output logic [`WORD_WIDTH-1:0] memAddress,
    output logic [`WORD_WIDTH-1:0] ir,
    output logic [`WORD_WIDTH-1:0] busValue
);

    logic [`WORD_WIDTH-1:0]   pc;
    logic [`WORD_WIDTH-1:0]   mdr;
    logic [`WORD_WIDTH-1:0]   y;
    logic [2*`WORD_WIDTH-1:0] z;
    logic [`WORD_WIDTH-1:0]   regValue;
    logic [`WORD_WIDTH-1:0]   hiValue;
    logic [`WORD_WIDTH-1:0]   loValue;
    logic [2*`WORD_WIDTH-1:0] aluResult;

    // PC, IR and MAR (memAddress) load from the bus
    always_ff @(posedge clock) begin
        if (rst) begin
            pc         <= '0;
            ir         <= '0;
            memAddress <= '0;
        end else begin
            if (pcIn)  pc <= busValue;
            if (irIn)  ir <= busValue;
            if (marIn) memAddress <= busValue;
        end
    end

    always_ff @(posedge clock) begin
        if (mdrIn) mdr <= memRead ? memDataIn : busValue; // Read selects memory side
        if (yIn)   y   <= busValue;
        if (zIn) begin
            // IncPC bypasses the ALU
            z <= incPc ? {{`WORD_WIDTH{1'b0}}, pc + 1'b1} : aluResult;
        end
    end

    registerFile regFile_i (
        .clock    (clock),
        .rst      (rst),
        .busValue (busValue),
        .regIn    (regIn),
        .regOut   (regOut),
        .hiIn     (hiIn),
        .loIn     (loIn),
        .regValue (regValue),
        .hiValue  (hiValue),
        .loValue  (loValue)
    );

    alu alu_i (
        .y        (y),
        .busValue (busValue),
        .aluOp    (aluOp),
        .result   (aluResult)
    );

    busMux busMux_i (
        .clock    (clock),
        .rst      (rst),
        .regOut   (regOut),
        .hiOut    (hiOut),
        .loOut    (loOut),
        .pcOut    (pcOut),
        .mdrOut   (mdrOut),
        .zLowOut  (zLowOut),
        .zHighOut (zHighOut),
        .regValue (regValue),
        .hiValue  (hiValue),
        .loValue  (loValue),
        .pc       (pc),
        .mdr      (mdr),
        .zValue   (z),
        .busValue (busValue)
    );

endmodule

/* datapath/registerFile.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module registerFile (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [`WORD_WIDTH-1:0] busValue,
    input  logic [`REG_COUNT-1:0]  regIn,
    input  logic [`REG_COUNT-1:0]  regOut,
    input  logic                   hiIn,
    input  logic                   loIn,
    output logic [`WORD_WIDTH-1:0] regValue,
    output logic [`WORD_WIDTH-1:0] hiValue,
    output logic [`WORD_WIDTH-1:0] loValue
);

    logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            hiValue <= '0;
            loValue <= '0;
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regIn[i]) regs[i] <= busValue; // R0in to R15in
            end
            if (hiIn) hiValue <= busValue;
            if (loIn) loValue <= busValue;
        end
    end

    // Read select is one-hot, so OR the masked registers together
    always_comb begin
        regValue = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regValue = regValue | (regs[i] & {`WORD_WIDTH{regOut[i]}});
        end
    end

    // Decoder must never write two registers from one bus value
    regInOneHot: assert property (@(posedge clock) disable iff (rst) $onehot0(regIn))
        else $error("registerFile: more than one register load strobe active");

endmodule

/* flist.f */
+incdir+common
common/isaPkg.sv
common/controlPkg.sv
datapath/registerFile.sv
datapath/alu.sv
datapath/busMux.sv
datapath/datapath.sv
hdl/controlUnit.sv
hdl/cpuCore.sv
tb/cpuCoreChecker.sv
tb/cpuCoreTb.sv

/* hdl/controlUnit.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module controlUnit (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [`WORD_WIDTH-1:0] ir,
    output logic                   pcOut,
    output logic                   pcIn,
    output logic                   incPc,
    output logic                   marIn,
    output logic                   mdrIn,
    output logic                   mdrOut,
    output logic                   irIn,
    output logic                   yIn,
    output logic                   zIn,
    output logic                   zLowOut,
    output logic                   zHighOut,
    output logic                   hiIn,
    output logic                   hiOut,
    output logic                   loIn,
    output logic                   loOut,
    output logic [`REG_COUNT-1:0]  regIn,
    output logic [`REG_COUNT-1:0]  regOut,
    output isaPkg::opcode_t        aluOp,
    output logic                   memRead,
    output logic                   outValid,
    output logic                   halted
);

    import isaPkg::*;
    import controlPkg::*;

    localparam logic [`REG_COUNT-1:0] hotBase = 1;

    step_t                    step;
    step_t                    nextStep;
    opcode_t                  op;
    logic [regFieldWidth-1:0] ra;
    logic [regFieldWidth-1:0] rb;
    logic [regFieldWidth-1:0] rc;
    logic [`REG_COUNT-1:0]    raHot;
    logic [`REG_COUNT-1:0]    rbHot;
    logic [`REG_COUNT-1:0]    rcHot;
    logic                     twoOperand;
    logic                     oneOperand;
    logic                     wideResult;

    // Instruction fields
    assign op = opcode_t'(ir[opLsb +: `OPCODE_WIDTH]);
    assign ra = ir[raLsb +: regFieldWidth];
    assign rb = ir[rbLsb +: regFieldWidth];
    assign rc = ir[rcLsb +: regFieldWidth];

    assign raHot = hotBase << ra;
    assign rbHot = hotBase << rb;
    assign rcHot = hotBase << rc;

    assign twoOperand = op inside {opAdd, opSub, opAnd, opOr, opShl, opShr, opMul, opDiv};
    assign oneOperand = op inside {opNot, opNeg};
    assign wideResult = op inside {opMul, opDiv}; // Results land in LO then HI

    assign halted = (step == stepHalted);

    always_ff @(posedge clock) begin
        if (rst) step <= stepT0;
        else     step <= nextStep;
    end

    always_comb begin
        {pcOut, pcIn, incPc, marIn, mdrIn, mdrOut, irIn, yIn, zIn} = '0;
        {zLowOut, zHighOut, hiIn, hiOut, loIn, loOut, memRead, outValid} = '0;
        regIn    = '0;
        regOut   = '0;
        aluOp    = opNop;
        nextStep = stepT0; // Default is the end of the instruction
        case (step)
            stepT0: begin
                {pcOut, marIn, incPc, zIn} = '1;
                nextStep = stepT1;
            end
            stepT1: begin
                {zLowOut, pcIn, memRead, mdrIn} = '1;
                nextStep = stepT2;
            end
            stepT2: begin
                {mdrOut, irIn} = '1;
                nextStep = stepT3;
            end
            stepT3: begin
                if (twoOperand) begin
                    regOut   = rbHot; // rb into Y
                    yIn      = 1'b1;
                    nextStep = stepT4;
                end else if (oneOperand) begin
                    regOut   = rbHot;
                    aluOp    = op;
                    zIn      = 1'b1;
                    nextStep = stepT4;
                end else begin
                    case (op)
                        opLdw: begin
                            // Data word follows the instruction
                            {pcOut, marIn, incPc, zIn} = '1;
                            nextStep = stepT4;
                        end
                        opMfhi: begin
                            hiOut = 1'b1;
                            regIn = raHot;
                        end
                        opMflo: begin
                            loOut = 1'b1;
                            regIn = raHot;
                        end
                        opOut: begin
                            regOut   = raHot;
                            outValid = 1'b1;
                        end
                        opHalt:  nextStep = stepHalted;
                        default: nextStep = stepT0; // nop and unused codes
                    endcase
                end
            end
            stepT4: begin
                if (twoOperand) begin
                    regOut   = rcHot;
                    aluOp    = op;
                    zIn      = 1'b1;
                    nextStep = stepT5;
                end else if (oneOperand) begin
                    zLowOut = 1'b1;
                    regIn   = raHot;
                end else if (op == opLdw) begin
                    {zLowOut, pcIn, memRead, mdrIn} = '1;
                    nextStep = stepT5;
                end
            end
            stepT5: begin
                if (wideResult) begin
                    {zLowOut, loIn} = '1;
                    nextStep = stepT6;
                end else if (twoOperand) begin
                    zLowOut = 1'b1;
                    regIn   = raHot;
                end else if (op == opLdw) begin
                    mdrOut = 1'b1;
                    regIn  = raHot;
                end
            end
            stepT6: {zHighOut, hiIn} = '1;
            stepHalted: nextStep = stepHalted; // Only reset leaves
            default: nextStep = stepT0;
        endcase
    end

endmodule

/* hdl/cpuCore.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module cpuCore (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [`WORD_WIDTH-1:0] memDataIn,
    output logic [`WORD_WIDTH-1:0] memAddress,
    output logic                   memRead,
    output logic [`WORD_WIDTH-1:0] outPort,
    output logic                   outValid,
    output logic                   halted
);

    import isaPkg::*;

    logic                   pcOut;
    logic                   pcIn;
    logic                   incPc;
    logic                   marIn;
    logic                   mdrIn;
    logic                   mdrOut;
    logic                   irIn;
    logic                   yIn;
    logic                   zIn;
    logic                   zLowOut;
    logic                   zHighOut;
    logic                   hiIn;
    logic                   hiOut;
    logic                   loIn;
    logic                   loOut;
    logic [`REG_COUNT-1:0]  regIn;
    logic [`REG_COUNT-1:0]  regOut;
    opcode_t                aluOp;
    logic [`WORD_WIDTH-1:0] ir;
    logic [`WORD_WIDTH-1:0] busValue;

    // Out instruction puts ra on the bus while outValid is high
    assign outPort = busValue;

    // Strobes share names between both blocks
    controlUnit controlUnit_i (.*);

    datapath datapath_i (.*);

endmodule

/* tb/cpuCoreChecker.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module cpuCoreChecker #(
    parameter int memWords = 256
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [`WORD_WIDTH-1:0] memImage [memWords],
    input  logic [`WORD_WIDTH-1:0] outPort,
    input  logic                   outValid,
    input  logic [`WORD_WIDTH-1:0] memAddress,
    input  logic                   memRead,
    input  logic                   halted,
    output int                     errorCount,
    output logic                   finished
);

    import isaPkg::*;

    localparam int resetLimit = 100;
    localparam int runLimit   = 5000;
    localparam int haltWindow = 50; // Quiet cycles required after halt

    logic [`WORD_WIDTH-1:0] expectValue [$];
    string                  expectName [$];
    logic [`WORD_WIDTH-1:0] expectAddr [$];
    int                     testCount;
    int                     outPulses;
    int                     readCount;
    int                     readErrors;

    // Instruction-set model stepping one instruction per pass
    task automatic runModel();
        logic [`WORD_WIDTH-1:0]   regs [`REG_COUNT];
        logic [`WORD_WIDTH-1:0]   hi;
        logic [`WORD_WIDTH-1:0]   lo;
        logic [`WORD_WIDTH-1:0]   word;
        logic [2*`WORD_WIDTH-1:0] product;
        logic [7:0]               pc;
        logic [regFieldWidth-1:0] ra;
        logic [regFieldWidth-1:0] rb;
        logic [regFieldWidth-1:0] rc;
        opcode_t                  op;
        string                    lastName;
        string                    hiLoName;
        int                       steps;
        bit                       running;
        for (int i = 0; i < `REG_COUNT; i++) regs[i] = '0;
        hi       = '0;
        lo       = '0;
        pc       = '0;
        lastName = "reset";
        hiLoName = "reset";
        running  = 1'b1;
        steps    = 0;
        while (running && steps < 2 * memWords) begin
            expectAddr.push_back(`WORD_WIDTH'(pc)); // Instruction fetch
            word = memImage[pc];
            pc   = pc + 8'd1;
            steps++;
            op = opcode_t'(word[opLsb +: `OPCODE_WIDTH]);
            ra = word[raLsb +: regFieldWidth];
            rb = word[rbLsb +: regFieldWidth];
            rc = word[rcLsb +: regFieldWidth];
            case (op)
                opLdw: begin
                    expectAddr.push_back(`WORD_WIDTH'(pc));
                    regs[ra] = memImage[pc]; // Data word after the instruction
                    pc       = pc + 8'd1;
                    lastName = "ldw";
                end
                opAdd: regs[ra] = regs[rb] + regs[rc];
                opSub: regs[ra] = regs[rb] - regs[rc];
                opAnd: regs[ra] = regs[rb] & regs[rc];
                opOr:  regs[ra] = regs[rb] | regs[rc];
                opShl: regs[ra] = regs[rb] << regs[rc][4:0];
                opShr: regs[ra] = regs[rb] >> regs[rc][4:0];
                opNot: regs[ra] = ~regs[rb];
                opNeg: regs[ra] = ~regs[rb] + 1'b1; // Two's complement
                opMul: begin
                    product  = 64'(regs[rb]) * 64'(regs[rc]);
                    hi       = product[2*`WORD_WIDTH-1:`WORD_WIDTH];
                    lo       = product[`WORD_WIDTH-1:0];
                    hiLoName = "mul";
                end
                opDiv: begin
                    if (regs[rc] == '0) begin
                        lo       = '1;
                        hi       = regs[rb];
                        hiLoName = "div by zero";
                    end else begin
                        lo       = regs[rb] / regs[rc];
                        hi       = regs[rb] % regs[rc];
                        hiLoName = "div";
                    end
                end
                opMfhi: regs[ra] = hi;
                opMflo: regs[ra] = lo;
                opOut: begin
                    expectName.push_back($sformatf("out%0d %s r%0d", expectValue.size(),
                        lastName, ra));
                    expectValue.push_back(regs[ra]);
                end
                opHalt:  running = 1'b0;
                default: ; // nop
            endcase
            if (op inside {opAdd, opSub, opAnd, opOr, opShl, opShr, opNot, opNeg}) begin
                lastName = op.name();
            end else if (op inside {opMfhi, opMflo}) begin
                lastName = {op.name(), " after ", hiLoName};
            end
        end
        if (running) begin
            $display("Model ran past the program without reaching a halt");
            errorCount++;
        end
    endtask

    task automatic checkOut();
        logic [`WORD_WIDTH-1:0] expected;
        string                  name;
        outPulses++;
        testCount++;
        if (expectValue.size() == 0) begin
            $display("Unexpected outValid pulse with no out instruction left, port %h", outPort);
            errorCount++;
        end else begin
            expected = expectValue.pop_front();
            name     = expectName.pop_front();
            if (outPort !== expected) begin
                $display("Error %s expected %h actual %h", name, expected, outPort);
                errorCount++;
            end else begin
                $display("ok    %s value %h", name, outPort);
            end
        end
    endtask

    task automatic checkRead();
        logic [`WORD_WIDTH-1:0] expected;
        readCount++;
        if (expectAddr.size() == 0) begin
            $display("Memory read at %h beyond the reads of the program", memAddress);
            readErrors++;
        end else begin
            expected = expectAddr.pop_front();
            if (memAddress !== expected) begin
                $display("Error read%0d address expected %h actual %h",
                    readCount - 1, expected, memAddress);
                readErrors++;
            end
        end
    endtask

    initial begin
        int cycles;
        int expectedOuts;
        int expectedReads;
        bit quiet;
        testCount  = 0;
        errorCount = 0;
        outPulses  = 0;
        readCount  = 0;
        readErrors = 0;
        finished   = 1'b0;
        cycles     = 0;
        while (rst !== 1'b0 && cycles < resetLimit) begin
            @(negedge clock);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Reset was not released within %0d cycles", resetLimit);
            errorCount++;
        end else begin
            runModel();
            expectedOuts  = expectValue.size();
            expectedReads = expectAddr.size();
            cycles        = 0;
            while (halted !== 1'b1 && cycles < runLimit) begin
                @(negedge clock); // Outputs settle by mid-cycle
                cycles++;
                if (memRead === 1'b1) checkRead();
                if (outValid === 1'b1) checkOut();
            end
            testCount++;
            if (halted !== 1'b1) begin
                $display("Core did not halt within %0d cycles", runLimit);
                errorCount++;
            end else begin
                quiet = 1'b1;
                for (int i = 0; i < haltWindow; i++) begin
                    @(negedge clock);
                    if (halted !== 1'b1 || outValid !== 1'b0 || memRead !== 1'b0) quiet = 1'b0;
                end
                if (quiet) begin
                    $display("ok    halt held quiet for %0d cycles", haltWindow);
                end else begin
                    $display("Core left halt or raised outValid or memRead after halt");
                    errorCount++;
                end
            end
            testCount++;
            if (outPulses != expectedOuts) begin
                $display("Error out count expected %0d actual %0d", expectedOuts, outPulses);
                errorCount++;
            end else begin
                $display("ok    out count %0d", outPulses);
            end
            testCount++;
            if (readCount != expectedReads) begin
                $display("Error memory read count expected %0d actual %0d",
                    expectedReads, readCount);
                errorCount++;
            end else if (readErrors != 0) begin
                $display("Memory read address wrong in %0d of %0d reads", readErrors, readCount);
                errorCount++;
            end else begin
                $display("ok    memory reads %0d", readCount);
            end
        end
        $display("Checks run: %0d, failed: %0d", testCount, errorCount);
        finished = 1'b1;
    end

endmodule

/* tb/cpuCoreTb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module cpuCoreTb;

    import isaPkg::*;

    localparam int memWords    = 256;
    localparam int finishLimit = 10000; // Cycles after reset

    logic                   clock;
    logic                   rst;
    logic [`WORD_WIDTH-1:0] memDataIn;
    logic [`WORD_WIDTH-1:0] memAddress;
    logic                   memRead;
    logic [`WORD_WIDTH-1:0] outPort;
    logic                   outValid;
    logic                   halted;
    logic [`WORD_WIDTH-1:0] mem [memWords];
    int                     seed;
    int                     progAddr;
    int                     errorCount;
    logic                   finished;

    // Word memory answers in the same cycle
    assign memDataIn = mem[memAddress[7:0]];

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [`WORD_WIDTH-1:0] encode(
        opcode_t    op,
        logic [3:0] ra,
        logic [3:0] rb,
        logic [3:0] rc
    );
        return {op, ra, rb, rc, 15'b0};
    endfunction

    task automatic emitWord(input logic [`WORD_WIDTH-1:0] word);
        mem[progAddr] = word;
        progAddr++;
    endtask

    task automatic buildProgram();
        logic [`WORD_WIDTH-1:0] r;
        logic [3:0]             ra;
        logic [3:0]             rb;
        logic [3:0]             rc;
        opcode_t                op;
        for (int i = 0; i < memWords; i++) begin
            mem[i] = 32'hc0de0000 | i; // Unused words tagged by address
        end
        progAddr = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            emitWord(encode(opLdw, 4'(i), 4'd0, 4'd0)); // Random start values
            emitWord($random(seed));
        end
        while (progAddr < memWords - 8) begin
            r  = $random(seed);
            ra = r[7:4];
            rb = r[11:8];
            rc = r[15:12];
            case (r[2:0])
                3'd0: begin
                    emitWord(encode(opLdw, ra, 4'd0, 4'd0));
                    emitWord($random(seed));
                    emitWord(encode(opOut, ra, 4'd0, 4'd0));
                end
                3'd5, 3'd6, 3'd7: begin
                    if (r[2:0] == 3'd7) begin
                        // Divisor forced to zero
                        emitWord(encode(opLdw, rc, 4'd0, 4'd0));
                        emitWord('0);
                    end
                    emitWord(encode(r[2:0] == 3'd5 ? opMul : opDiv, 4'd0, rb, rc));
                    emitWord(encode(opMfhi, ra, 4'd0, 4'd0));
                    emitWord(encode(opOut, ra, 4'd0, 4'd0));
                    emitWord(encode(opMflo, ra, 4'd0, 4'd0));
                    emitWord(encode(opOut, ra, 4'd0, 4'd0));
                end
                default: begin
                    case (r[2:0])
                        3'd3:    op = r[16] ? opShl : opShr;
                        3'd4:    op = r[16] ? opNot : opNeg;
                        default: op = r[17] ? (r[16] ? opOr : opAnd) : (r[16] ? opSub : opAdd);
                    endcase
                    emitWord(encode(op, ra, rb, rc));
                    emitWord(encode(opOut, ra, 4'd0, 4'd0));
                end
            endcase
        end
        emitWord(encode(opHalt, 4'd0, 4'd0, 4'd0));
    endtask

    initial begin
        int cycles;
        bit timedOut;
        seed = 32'h1409ab1c;
        rst  = 1'b1;
        buildProgram();
        repeat (10) @(posedge clock);
        rst <= 1'b0;
        cycles = 0;
        while (finished !== 1'b1 && cycles < finishLimit) begin
            @(posedge clock);
            cycles++;
        end
        timedOut = (finished !== 1'b1);
        if (timedOut) $display("Checker did not finish within %0d cycles", finishLimit);
        if (timedOut || errorCount != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

    cpuCore cpuCore_i (
        .clock      (clock),
        .rst        (rst),
        .memDataIn  (memDataIn),
        .memAddress (memAddress),
        .memRead    (memRead),
        .outPort    (outPort),
        .outValid   (outValid),
        .halted     (halted)
    );

    cpuCoreChecker #(.memWords(memWords)) coreChecker_i (
        .clock      (clock),
        .rst        (rst),
        .memImage   (mem),
        .outPort    (outPort),
        .outValid   (outValid),
        .memAddress (memAddress),
        .memRead    (memRead),
        .halted     (halted),
        .errorCount (errorCount),
        .finished   (finished)
    );

endmodule
